/* hdl/exePkg.sv */
`default_nettype none

package exePkg;

    ////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////

    parameter int WORD_WIDTH     = 32;
    parameter int REG_ADDR_WIDTH = 5;   // 32 gprs
    parameter int BE_WIDTH       = 4;   // byte lanes per word
    parameter int BYTE_WIDTH     = 8;
    parameter int HALF_WIDTH     = 16;
    parameter int SHAMT_WIDTH    = 5;   // shift amount taken from operand 0

    ////////////////////////////////////////////////////////////////////
    // opcodes and selects
    ////////////////////////////////////////////////////////////////////

    // alu operation, signed variants trap on overflow
    typedef enum logic [3:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI
    } aluOp_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } memOp_e;

    // where an operand comes from
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_FWD_EXE,     // result of the stage ahead
        SRC_FWD_MEM      // result of the memory stage
    } srcSel_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OV,          // signed add/sub overflow
        EXC_ADEL,        // misaligned load
        EXC_ADES         // misaligned store
    } excCode_e;

endpackage

`default_nettype wire

/* hdl/exeStageReg.sv */
`timescale 1ns/10ps
`default_nettype none

module exeStageReg import exePkg::*; (
    input  wire                        clk,
    input  wire                        rst,
    // upstream side
    input  wire                        inValid_i,
    output logic                       inReady_o,
    input  wire                        flush_i,
    input  wire aluOp_e                aluOp_i,
    input  wire memOp_e                memOp_i,
    input  wire srcSel_e               src0Sel_i,
    input  wire srcSel_e               src1Sel_i,
    input  wire srcSel_e               storeSel_i,
    input  wire [WORD_WIDTH-1:0]       regData0_i,
    input  wire [WORD_WIDTH-1:0]       regData1_i,
    input  wire [WORD_WIDTH-1:0]       imm_i,
    input  wire [WORD_WIDTH-1:0]       fwdExe_i,
    input  wire [WORD_WIDTH-1:0]       fwdMem_i,
    input  wire [REG_ADDR_WIDTH-1:0]   destReg_i,
    // downstream side
    output logic                       outValid_o,
    input  wire                        outReady_i,
    output aluOp_e                     heldAluOp_o,
    output memOp_e                     heldMemOp_o,
    output srcSel_e                    heldSrc0Sel_o,
    output srcSel_e                    heldSrc1Sel_o,
    output srcSel_e                    heldStoreSel_o,
    output logic [WORD_WIDTH-1:0]      heldReg0_o,
    output logic [WORD_WIDTH-1:0]      heldReg1_o,
    output logic [WORD_WIDTH-1:0]      heldImm_o,
    output logic [WORD_WIDTH-1:0]      heldFwdExe_o,
    output logic [WORD_WIDTH-1:0]      heldFwdMem_o,
    output logic [REG_ADDR_WIDTH-1:0]  heldDest_o
);

    logic full;      // slot occupied
    logic accept;
    logic depart;

    ////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////

    // a leaving instruction frees the slot in the same edge
    assign inReady_o  = !flush_i && (!full || outReady_i);
    assign outValid_o = full && !flush_i;
    assign accept     = inValid_i && inReady_o;
    assign depart     = outValid_o && outReady_i;

    // memOp falls back to MEM_NONE when empty so no stray request leaks out
    always_ff @(posedge clk) begin
        if (!rst) begin
            full        <= 1'b0;
            heldMemOp_o <= MEM_NONE;
        end else if (accept) begin
            full        <= 1'b1;
            heldMemOp_o <= memOp_i;
        end else if (flush_i || depart) begin
            full        <= 1'b0;
            heldMemOp_o <= MEM_NONE;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // instruction fields, forwards captured with the instruction
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            heldAluOp_o    <= aluOp_i;
            heldSrc0Sel_o  <= src0Sel_i;
            heldSrc1Sel_o  <= src1Sel_i;
            heldStoreSel_o <= storeSel_i;
            heldReg0_o     <= regData0_i;
            heldReg1_o     <= regData1_i;
            heldImm_o      <= imm_i;
            heldFwdExe_o   <= fwdExe_i;   // snapshot, later forwards ignored
            heldFwdMem_o   <= fwdMem_i;
            heldDest_o     <= destReg_i;
        end
    end

    // a stalled instruction must look the same on the next cycle
    property heldStableP;
        @(posedge clk) disable iff (!rst)
        outValid_o && !outReady_i |=> $stable({heldAluOp_o, heldMemOp_o,
            heldSrc0Sel_o, heldSrc1Sel_o, heldStoreSel_o, heldReg0_o,
            heldReg1_o, heldImm_o, heldFwdExe_o, heldFwdMem_o, heldDest_o});
    endproperty

    heldStableA: assert property (heldStableP)
        else $error("held fields changed under back-pressure");

endmodule

`default_nettype wire

/* hdl/exeAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module exeAlu import exePkg::*; (
    input  wire                    outValid_i,
    input  wire aluOp_e            heldAluOp_i,
    input  wire srcSel_e           heldSrc0Sel_i,
    input  wire srcSel_e           heldSrc1Sel_i,
    input  wire srcSel_e           heldStoreSel_i,
    input  wire [WORD_WIDTH-1:0]   heldReg0_i,
    input  wire [WORD_WIDTH-1:0]   heldReg1_i,
    input  wire [WORD_WIDTH-1:0]   heldImm_i,
    input  wire [WORD_WIDTH-1:0]   heldFwdExe_i,
    input  wire [WORD_WIDTH-1:0]   heldFwdMem_i,
    output logic [WORD_WIDTH-1:0]  aluRes_o,
    output logic                   overflow_o,
    output logic [WORD_WIDTH-1:0]  storeValue_o
);

    localparam int MSB = WORD_WIDTH - 1;

    logic [WORD_WIDTH-1:0]  op0;
    logic [WORD_WIDTH-1:0]  op1;
    logic [WORD_WIDTH-1:0]  sum;
    logic [WORD_WIDTH-1:0]  diff;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic                   addOv;
    logic                   subOv;

    ////////////////////////////////////////////////////////////////////
    // operand resolution
    ////////////////////////////////////////////////////////////////////

    function automatic logic [WORD_WIDTH-1:0] pickSrc(
        input srcSel_e               sel,
        input logic [WORD_WIDTH-1:0] regVal,
        input logic [WORD_WIDTH-1:0] immVal,
        input logic [WORD_WIDTH-1:0] exeVal,
        input logic [WORD_WIDTH-1:0] memVal
    );
        case (sel)
            SRC_REG:     return regVal;
            SRC_IMM:     return immVal;
            SRC_FWD_EXE: return exeVal;
            default:     return memVal;
        endcase
    endfunction

    assign op0 = pickSrc(heldSrc0Sel_i, heldReg0_i, heldImm_i, heldFwdExe_i, heldFwdMem_i);
    assign op1 = pickSrc(heldSrc1Sel_i, heldReg1_i, heldImm_i, heldFwdExe_i, heldFwdMem_i);

    // store value always pairs with the second register read port
    assign storeValue_o = pickSrc(heldStoreSel_i, heldReg1_i, heldImm_i,
                                  heldFwdExe_i, heldFwdMem_i);

    ////////////////////////////////////////////////////////////////////
    // arithmetic
    ////////////////////////////////////////////////////////////////////

    assign sum   = op0 + op1;
    assign diff  = op0 - op1;
    assign shamt = op0[SHAMT_WIDTH-1:0];

    // same input signs, result sign flipped
    assign addOv = (op0[MSB] == op1[MSB]) && (sum[MSB] != op0[MSB]);
    assign subOv = (op0[MSB] != op1[MSB]) && (diff[MSB] != op0[MSB]);

    always_comb begin
        overflow_o = 1'b0;
        case (heldAluOp_i)
            ADD: begin
                aluRes_o   = sum;
                overflow_o = addOv;
            end
            ADDU: aluRes_o = sum;
            SUB: begin
                aluRes_o   = diff;
                overflow_o = subOv;
            end
            SUBU: aluRes_o = diff;
            AND:  aluRes_o = op0 & op1;
            OR:   aluRes_o = op0 | op1;
            XOR:  aluRes_o = op0 ^ op1;
            NOR:  aluRes_o = ~(op0 | op1);
            SLT:  aluRes_o = WORD_WIDTH'($signed(op0) < $signed(op1));
            SLTU: aluRes_o = WORD_WIDTH'(op0 < op1);
            SLL:  aluRes_o = op1 << shamt;
            SRL:  aluRes_o = op1 >> shamt;
            SRA:  aluRes_o = $signed(op1) >>> shamt;   // sign fill
            LUI:  aluRes_o = {op1[HALF_WIDTH-1:0], {HALF_WIDTH{1'b0}}};
            default: aluRes_o = sum;
        endcase
    end

    // decode never routes an immediate into the store path
    always_comb begin
        if (outValid_i) begin
            storeSelA: assert final (heldStoreSel_i != SRC_IMM)
                else $error("store value selected from immediate");
        end
    end

endmodule

`default_nettype wire

/* hdl/memAccessFormat.sv */
`timescale 1ns/10ps
`default_nettype none

module memAccessFormat import exePkg::*; (
    input  wire memOp_e            heldMemOp_i,
    input  wire [WORD_WIDTH-1:0]   aluRes_i,       // effective address
    input  wire                    overflow_i,
    input  wire [WORD_WIDTH-1:0]   storeValue_i,
    output logic                   memReq_o,
    output logic                   memWrite_o,
    output logic [BE_WIDTH-1:0]    byteEnable_o,
    output logic [WORD_WIDTH-1:0]  storeData_o,
    output excCode_e               excCode_o
);

    logic       isByte;
    logic       isHalf;
    logic       isWord;
    logic       isLoad;
    logic       isStore;
    logic       misaligned;
    logic [1:0] offset;
    logic [BE_WIDTH-1:0] rawEnable;

    assign offset = aluRes_i[1:0];

    ////////////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        isByte  = 1'b0;
        isHalf  = 1'b0;
        isWord  = 1'b0;
        isLoad  = 1'b0;
        isStore = 1'b0;
        case (heldMemOp_i)
            LB, LBU: begin
                isByte = 1'b1;
                isLoad = 1'b1;
            end
            LH, LHU: begin
                isHalf = 1'b1;
                isLoad = 1'b1;
            end
            LW: begin
                isWord = 1'b1;
                isLoad = 1'b1;
            end
            SB: begin
                isByte  = 1'b1;
                isStore = 1'b1;
            end
            SH: begin
                isHalf  = 1'b1;
                isStore = 1'b1;
            end
            SW: begin
                isWord  = 1'b1;
                isStore = 1'b1;
            end
            default: ;   // no access
        endcase
    end

    // half needs bit 0 clear, word needs both low bits clear
    assign misaligned = (isHalf && offset[0]) || (isWord && (offset != 2'b00));

    ////////////////////////////////////////////////////////////////////
    // lanes and store data
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        rawEnable = '0;
        if (isByte) begin
            rawEnable = BE_WIDTH'(1) << offset;
        end else if (isHalf) begin
            rawEnable = offset[1] ? 4'b1100 : 4'b0011;
        end else if (isWord) begin
            rawEnable = '1;
        end
    end

    always_comb begin
        if (isStore && isByte) begin
            storeData_o = {BE_WIDTH{storeValue_i[BYTE_WIDTH-1:0]}};
        end else if (isStore && isHalf) begin
            storeData_o = {2{storeValue_i[HALF_WIDTH-1:0]}};
        end else if (isStore) begin
            storeData_o = storeValue_i;
        end else begin
            storeData_o = '0;   // loads carry no data
        end
    end

    ////////////////////////////////////////////////////////////////////
    // exceptions and request
    ////////////////////////////////////////////////////////////////////

    // overflow first, then load, then store misalignment
    always_comb begin
        if (overflow_i) begin
            excCode_o = EXC_OV;
        end else if (isLoad && misaligned) begin
            excCode_o = EXC_ADEL;
        end else if (isStore && misaligned) begin
            excCode_o = EXC_ADES;
        end else begin
            excCode_o = EXC_NONE;
        end
    end

    assign memReq_o     = (isLoad || isStore) && (excCode_o == EXC_NONE);
    assign memWrite_o   = isStore;
    assign byteEnable_o = (overflow_i || misaligned) ? '0 : rawEnable;   // raw fault terms

    // a faulting access never touches a lane
    always_comb begin
        if (excCode_o != EXC_NONE) begin
            excLanesA: assert final (byteEnable_o == '0)
                else $error("byte enables active on exception");
        end
    end

endmodule

`default_nettype wire

/* hdl/exeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module exeStage import exePkg::*; (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        flush_i,
    // from decode
    input  wire                        inValid_i,
    output logic                       inReady_o,
    input  wire aluOp_e                aluOp_i,
    input  wire memOp_e                memOp_i,
    input  wire srcSel_e               src0Sel_i,
    input  wire srcSel_e               src1Sel_i,
    input  wire srcSel_e               storeSel_i,
    input  wire [WORD_WIDTH-1:0]       regData0_i,
    input  wire [WORD_WIDTH-1:0]       regData1_i,
    input  wire [WORD_WIDTH-1:0]       imm_i,
    input  wire [WORD_WIDTH-1:0]       fwdExe_i,
    input  wire [WORD_WIDTH-1:0]       fwdMem_i,
    input  wire [REG_ADDR_WIDTH-1:0]   destReg_i,
    // to memory stage
    output logic                       outValid_o,
    input  wire                        outReady_i,
    output logic [WORD_WIDTH-1:0]      result_o,
    output logic [REG_ADDR_WIDTH-1:0]  destReg_o,
    output logic                       memReq_o,
    output logic                       memWrite_o,
    output memOp_e                     memOp_o,
    output logic [BE_WIDTH-1:0]        byteEnable_o,
    output logic [WORD_WIDTH-1:0]      storeData_o,
    output excCode_e                   excCode_o
);

    aluOp_e                  heldAluOp;
    srcSel_e                 heldSrc0Sel;
    srcSel_e                 heldSrc1Sel;
    srcSel_e                 heldStoreSel;
    logic [WORD_WIDTH-1:0]   heldReg0;
    logic [WORD_WIDTH-1:0]   heldReg1;
    logic [WORD_WIDTH-1:0]   heldImm;
    logic [WORD_WIDTH-1:0]   heldFwdExe;
    logic [WORD_WIDTH-1:0]   heldFwdMem;
    logic [WORD_WIDTH-1:0]   aluRes;
    logic [WORD_WIDTH-1:0]   storeValue;
    logic                    overflow;

    exeStageReg stageReg (
        .clk            (clk),
        .rst            (rst),
        .inValid_i      (inValid_i),
        .inReady_o      (inReady_o),
        .flush_i        (flush_i),
        .aluOp_i        (aluOp_i),
        .memOp_i        (memOp_i),
        .src0Sel_i      (src0Sel_i),
        .src1Sel_i      (src1Sel_i),
        .storeSel_i     (storeSel_i),
        .regData0_i     (regData0_i),
        .regData1_i     (regData1_i),
        .imm_i          (imm_i),
        .fwdExe_i       (fwdExe_i),
        .fwdMem_i       (fwdMem_i),
        .destReg_i      (destReg_i),
        .outValid_o     (outValid_o),
        .outReady_i     (outReady_i),
        .heldAluOp_o    (heldAluOp),
        .heldMemOp_o    (memOp_o),       // goes straight out
        .heldSrc0Sel_o  (heldSrc0Sel),
        .heldSrc1Sel_o  (heldSrc1Sel),
        .heldStoreSel_o (heldStoreSel),
        .heldReg0_o     (heldReg0),
        .heldReg1_o     (heldReg1),
        .heldImm_o      (heldImm),
        .heldFwdExe_o   (heldFwdExe),
        .heldFwdMem_o   (heldFwdMem),
        .heldDest_o     (destReg_o)
    );

    exeAlu alu (
        .outValid_i     (outValid_o),
        .heldAluOp_i    (heldAluOp),
        .heldSrc0Sel_i  (heldSrc0Sel),
        .heldSrc1Sel_i  (heldSrc1Sel),
        .heldStoreSel_i (heldStoreSel),
        .heldReg0_i     (heldReg0),
        .heldReg1_i     (heldReg1),
        .heldImm_i      (heldImm),
        .heldFwdExe_i   (heldFwdExe),
        .heldFwdMem_i   (heldFwdMem),
        .aluRes_o       (aluRes),
        .overflow_o     (overflow),
        .storeValue_o   (storeValue)
    );

    assign result_o = aluRes;   // also the memory address

    memAccessFormat memFormat (
        .heldMemOp_i    (memOp_o),
        .aluRes_i       (aluRes),
        .overflow_i     (overflow),
        .storeValue_i   (storeValue),
        .memReq_o       (memReq_o),
        .memWrite_o     (memWrite_o),
        .byteEnable_o   (byteEnable_o),
        .storeData_o    (storeData_o),
        .excCode_o      (excCode_o)
    );

endmodule

`default_nettype wire

/* tests/exeStageModel.svh */
`ifndef EXE_STAGE_MODEL_SVH
`define EXE_STAGE_MODEL_SVH

`default_nettype none

// what one instruction should look like at the stage output
typedef struct packed {
    logic [31:0]      result;
    logic [4:0]       dest;
    logic             memReq;
    logic             memWrite;
    exePkg::memOp_e   memOp;
    logic [3:0]       byteEnable;
    logic [31:0]      storeData;
    exePkg::excCode_e exc;
} expectedRec_s;

function automatic logic [31:0] lcgStep(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] pickOperand(
    input exePkg::srcSel_e sel,
    input logic [31:0]     regVal,
    input logic [31:0]     immVal,
    input logic [31:0]     exeVal,
    input logic [31:0]     memVal
);
    if (sel == exePkg::SRC_IMM) return immVal;
    if (sel == exePkg::SRC_FWD_EXE) return exeVal;
    if (sel == exePkg::SRC_FWD_MEM) return memVal;
    return regVal;
endfunction

// returns {overflow, result}
function automatic logic [32:0] aluReference(
    input exePkg::aluOp_e op,
    input logic [31:0]    a,
    input logic [31:0]    b
);
    longint      wide;
    logic [31:0] res;
    logic        ov;
    logic [4:0]  sh;
    ov = 1'b0;
    sh = a[4:0];
    case (op)
        exePkg::ADD, exePkg::ADDU: wide = longint'($signed(a)) + longint'($signed(b));
        exePkg::SUB, exePkg::SUBU: wide = longint'($signed(a)) - longint'($signed(b));
        default:                   wide = 0;
    endcase
    case (op)
        exePkg::ADD, exePkg::ADDU, exePkg::SUB, exePkg::SUBU: res = wide[31:0];
        exePkg::AND:  res = a & b;
        exePkg::OR:   res = a | b;
        exePkg::XOR:  res = a ^ b;
        exePkg::NOR:  res = ~(a | b);
        exePkg::SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exePkg::SLTU: res = (a < b) ? 32'd1 : 32'd0;
        exePkg::SLL:  res = b << sh;
        exePkg::SRL:  res = b >> sh;
        exePkg::SRA:  res = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
        default:      res = {b[15:0], 16'h0000};   // lui
    endcase
    // only the trapping forms report it
    if (op == exePkg::ADD || op == exePkg::SUB) begin
        ov = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
    end
    return {ov, res};
endfunction

function automatic expectedRec_s buildExpected(
    input exePkg::aluOp_e  aluOp,
    input exePkg::memOp_e  memOp,
    input exePkg::srcSel_e src0Sel,
    input exePkg::srcSel_e src1Sel,
    input exePkg::srcSel_e storeSel,
    input logic [31:0]     reg0,
    input logic [31:0]     reg1,
    input logic [31:0]     imm,
    input logic [31:0]     fwdExe,
    input logic [31:0]     fwdMem,
    input logic [4:0]      dest
);
    expectedRec_s rec;
    logic [32:0]  aluOut;
    logic [31:0]  storeVal;
    logic [1:0]   offset;
    int           size;   // bytes per access
    logic         isStore;
    logic         bad;
    aluOut   = aluReference(aluOp, pickOperand(src0Sel, reg0, imm, fwdExe, fwdMem),
                            pickOperand(src1Sel, reg1, imm, fwdExe, fwdMem));
    storeVal = pickOperand(storeSel, reg1, imm, fwdExe, fwdMem);
    offset   = aluOut[1:0];
    case (memOp)
        exePkg::LB, exePkg::LBU, exePkg::SB: size = 1;
        exePkg::LH, exePkg::LHU, exePkg::SH: size = 2;
        exePkg::LW, exePkg::SW:              size = 4;
        default:                             size = 0;
    endcase
    isStore = (memOp == exePkg::SB) || (memOp == exePkg::SH) || (memOp == exePkg::SW);
    bad     = (size == 2 && offset[0]) || (size == 4 && offset != 2'b00);

    rec.result   = aluOut[31:0];
    rec.dest     = dest;
    rec.memOp    = memOp;
    rec.memWrite = isStore;
    if (aluOut[32]) rec.exc = exePkg::EXC_OV;
    else if (bad && !isStore) rec.exc = exePkg::EXC_ADEL;
    else if (bad) rec.exc = exePkg::EXC_ADES;
    else rec.exc = exePkg::EXC_NONE;
    rec.memReq     = (size != 0) && (rec.exc == exePkg::EXC_NONE);
    rec.byteEnable = 4'b0000;
    if (rec.exc == exePkg::EXC_NONE) begin
        case (size)
            1:       rec.byteEnable = 4'b0001 << offset;
            2:       rec.byteEnable = offset[1] ? 4'b1100 : 4'b0011;
            4:       rec.byteEnable = 4'b1111;
            default: rec.byteEnable = 4'b0000;
        endcase
    end
    case (size)
        1:       rec.storeData = {4{storeVal[7:0]}};
        2:       rec.storeData = {2{storeVal[15:0]}};
        default: rec.storeData = storeVal;
    endcase
    return rec;
endfunction

`default_nettype wire

`endif

/* tests/tbExeStage.sv */
`timescale 1ns/10ps
`include "exeStageModel.svh"
`default_nettype none

module tbExeStage import exePkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_INSTR  = 3000;
    localparam int TIMEOUT_NS = NUM_INSTR * CLK_PERIOD * 8;

    logic                       clk;
    logic                       rst;
    logic                       flush_i;
    logic                       inValid_i;
    logic                       inReady_o;
    aluOp_e                     aluOp_i;
    memOp_e                     memOp_i;
    srcSel_e                    src0Sel_i;
    srcSel_e                    src1Sel_i;
    srcSel_e                    storeSel_i;
    logic [WORD_WIDTH-1:0]      regData0_i;
    logic [WORD_WIDTH-1:0]      regData1_i;
    logic [WORD_WIDTH-1:0]      imm_i;
    logic [WORD_WIDTH-1:0]      fwdExe_i;
    logic [WORD_WIDTH-1:0]      fwdMem_i;
    logic [REG_ADDR_WIDTH-1:0]  destReg_i;
    logic                       outValid_o;
    logic                       outReady_i;
    logic [WORD_WIDTH-1:0]      result_o;
    logic [REG_ADDR_WIDTH-1:0]  destReg_o;
    logic                       memReq_o;
    logic                       memWrite_o;
    memOp_e                     memOp_o;
    logic [BE_WIDTH-1:0]        byteEnable_o;
    logic [WORD_WIDTH-1:0]      storeData_o;
    excCode_e                   excCode_o;

    logic [31:0]  lcgState;
    expectedRec_s expQ[$];     // never more than one entry
    logic         modelFull;
    int           retired;

    exeStage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] draw();
        lcgState = lcgStep(lcgState);
        return lcgState ^ (lcgState >> 16);   // fold high bits into weak low bits
    endfunction

    task automatic stopWithFailure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string sigName, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            $display("mismatch at %0t ns: %s got 0x%h expected 0x%h",
                     $time, sigName, got, want);
            stopWithFailure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////

    task automatic driveRandom();
        logic [31:0] pick;
        inValid_i  = (draw() % 4) != 0;
        outReady_i = (draw() % 10) >= 3;   // low about 30 %
        flush_i    = (draw() % 20) == 0;
        aluOp_i    = aluOp_e'(draw() % 14);
        memOp_i    = memOp_e'(draw() % 9);
        src0Sel_i  = srcSel_e'(draw() % 4);
        src1Sel_i  = srcSel_e'(draw() % 4);
        pick       = draw() % 3;
        storeSel_i = (pick == 0) ? SRC_REG : ((pick == 1) ? SRC_FWD_EXE : SRC_FWD_MEM);
        regData0_i = draw();
        regData1_i = (draw() % 8 == 0) ? regData0_i : draw();   // equal operands now and then
        imm_i      = draw();
        fwdExe_i   = draw();   // changes every cycle, only the captured one counts
        fwdMem_i   = draw();
        destReg_i  = REG_ADDR_WIDTH'(draw());
        // base plus small offset, low address bits mostly nonzero
        if (memOp_i != MEM_NONE && draw() % 4 != 0) begin
            aluOp_i   = (draw() % 2 == 0) ? ADD : ADDU;
            src1Sel_i = SRC_IMM;
            imm_i     = draw() % 16;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////////////

    task automatic compareOutputs(input expectedRec_s want);
        checkValue("result_o", result_o, want.result);
        checkValue("destReg_o", destReg_o, want.dest);
        checkValue("memOp_o", memOp_o, want.memOp);
        checkValue("excCode_o", excCode_o, want.exc);
        checkValue("memReq_o", memReq_o, want.memReq);
        checkValue("memWrite_o", memWrite_o, want.memWrite);
        checkValue("byteEnable_o", byteEnable_o, want.byteEnable);
        if (want.memWrite) begin
            checkValue("storeData_o", storeData_o, want.storeData);
        end
    endtask

    // runs between falling and rising edge, inputs already settled
    task automatic scoreCycle();
        logic         accept;
        logic         depart;
        expectedRec_s want;
        checkValue("outValid_o", outValid_o, modelFull && !flush_i);
        checkValue("inReady_o", inReady_o, !flush_i && (!modelFull || outReady_i));
        accept = inValid_i && inReady_o;
        depart = outValid_o && outReady_i;
        if (depart) begin
            want = expQ.pop_front();
            compareOutputs(want);
            retired++;
        end else if (flush_i && modelFull) begin
            want = expQ.pop_front();   // flushed, must never show up
        end
        if (accept) begin
            expQ.push_back(buildExpected(aluOp_i, memOp_i, src0Sel_i, src1Sel_i, storeSel_i,
                                         regData0_i, regData1_i, imm_i, fwdExe_i, fwdMem_i,
                                         destReg_i));
        end
        modelFull = accept || (modelFull && !depart && !flush_i);
    endtask

    initial begin
        lcgState   = 32'ha48e1c12;
        rst        = 1'b0;
        flush_i    = 1'b0;
        inValid_i  = 1'b0;
        outReady_i = 1'b0;
        aluOp_i    = ADD;
        memOp_i    = MEM_NONE;
        src0Sel_i  = SRC_REG;
        src1Sel_i  = SRC_REG;
        storeSel_i = SRC_REG;
        regData0_i = '0;
        regData1_i = '0;
        imm_i      = '0;
        fwdExe_i   = '0;
        fwdMem_i   = '0;
        destReg_i  = '0;
        modelFull  = 1'b0;
        retired    = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        #1;
        checkValue("outValid_o", outValid_o, 1'b0);
        checkValue("memReq_o", memReq_o, 1'b0);
        checkValue("inReady_o", inReady_o, 1'b1);
        while (retired < NUM_INSTR) begin
            @(negedge clk);
            driveRandom();
            #1;
            scoreCycle();
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: fewer than %0d instructions left the stage in time", NUM_INSTR);
        stopWithFailure();
    end

endmodule

`default_nettype wire

/* exeStage.f */
+incdir+tests
hdl/exePkg.sv
hdl/exeStageReg.sv
hdl/exeAlu.sv
hdl/memAccessFormat.sv
hdl/exeStage.sv
tests/tbExeStage.sv

/* Bender.yml */
package:
  name: exeStage

sources:
  # synthesizable design, package first
  - files:
      - hdl/exePkg.sv
      - hdl/exeStageReg.sv
      - hdl/exeAlu.sv
      - hdl/memAccessFormat.sv
      - hdl/exeStage.sv

  # simulation only
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tbExeStage.sv
